/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_banked_store -f sim.f --Mdir obj_dir -o sim_banked_store
	./obj_dir/sim_banked_store +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/store_chk.sv */
`timescale 1ns/1ps

module store_chk import store_pkg::*; (
    input logic clock,
    input logic reset,
    input logic grant_a,
    input logic grant_b,
    input logic bank0_valid,
    input logic bank0_ready,
    input logic bank0_tag,
    input logic bank0_rsp_valid,
    input logic bank1_valid,
    input logic bank1_ready,
    input logic bank1_tag,
    input logic bank1_rsp_valid
);
    int   failures = 0;
    logic busy0;   // Bank 0 owes a response.
    logic busy1;
    logic owner0;  // Port that bank 0 serves, 1 for port b.
    logic owner1;
    logic held_a;
    logic held_b;

    // A port is held while either bank still owes it a response.
    assign held_a = (busy0 && !owner0) || (busy1 && !owner1);
    assign held_b = (busy0 && owner0) || (busy1 && owner1);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy0 <= 1'b0;
            busy1 <= 1'b0;
        end else begin
            if (bank0_valid && bank0_ready)
                busy0 <= 1'b1;
            else if (bank0_rsp_valid)
                busy0 <= 1'b0;
            if (bank1_valid && bank1_ready)
                busy1 <= 1'b1;
            else if (bank1_rsp_valid)
                busy1 <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (bank0_valid && bank0_ready)
            owner0 <= bank0_tag;
        if (bank1_valid && bank1_ready)
            owner1 <= bank1_tag;
    end

    // ----------------------------------------
    // Arbiter rules
    // ----------------------------------------
    assert property (@(posedge clock) disable iff (reset)
        !((grant_a && held_a) || (grant_b && held_b)))
        else begin
            $error("a port was granted while its previous response was pending");
            failures++;
        end

    // A bank may take a new request in the cycle of its response, never earlier.
    assert property (@(posedge clock) disable iff (reset)
        !((bank0_valid && bank0_ready && busy0 && !bank0_rsp_valid) ||
          (bank1_valid && bank1_ready && busy1 && !bank1_rsp_valid)))
        else begin
            $error("a bank accepted a request while it was busy");
            failures++;
        end

    assert property (@(posedge clock) disable iff (reset)
        !((bank0_rsp_valid && !busy0) || (bank1_rsp_valid && !busy1)))
        else begin
            $error("a bank responded with no request outstanding");
            failures++;
        end

endmodule

/* bench/store_monitor.sv */
`timescale 1ns/1ps

module store_monitor import store_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 req_valid_a,
    input  store_op_t            req_op_a,
    input  logic [ADDR_BITS-1:0] req_addr_a,
    input  logic [SEG_BITS-1:0]  req_wdata_a,
    input  logic                 req_ready_a,
    input  logic                 rsp_valid_a,
    input  logic [SEG_BITS-1:0]  rsp_data_a,
    input  logic                 req_valid_b,
    input  store_op_t            req_op_b,
    input  logic [ADDR_BITS-1:0] req_addr_b,
    input  logic [SEG_BITS-1:0]  req_wdata_b,
    input  logic                 req_ready_b,
    input  logic                 rsp_valid_b,
    input  logic [SEG_BITS-1:0]  rsp_data_b,
    input  logic                 final_check,
    output int                   data_errors,
    output int                   orphan_errors,
    output int                   leftover_errors,
    output int                   startup_errors,
    output int                   stall_cycles,
    output int                   pending
);
    logic [SEG_BITS-1:0] model [1 << ADDR_BITS];  // Every segment, by full address.
    logic [SEG_BITS-1:0] expect_a [$];
    logic [SEG_BITS-1:0] expect_b [$];
    logic                first_cycle;
    logic                final_done;

    function automatic logic [SEG_BITS-1:0] apply_request(
        input store_op_t            op,
        input logic [ADDR_BITS-1:0] addr,
        input logic [SEG_BITS-1:0]  wdata
    );
        if (op == OP_WRITE) begin
            model[addr] = wdata;
            return '0;  // A write answers with zero.
        end
        return model[addr];
    endfunction

    task automatic check_response(input bit is_b, input logic [SEG_BITS-1:0] actual);
        string               name;
        logic [SEG_BITS-1:0] expected;
        name = is_b ? "b" : "a";
        if ((is_b ? expect_b.size() : expect_a.size()) == 0) begin
            orphan_errors++;
            $display("Port %s gave a response at %0d ns with no request outstanding.",
                     name, $time);
        end else begin
            if (is_b)
                expected = expect_b.pop_front();
            else
                expected = expect_a.pop_front();
            if (actual !== expected) begin
                data_errors++;
                $display("error at %0d ns: port %s expected %h, got %h",
                         $time, name, expected, actual);
            end
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < (1 << ADDR_BITS); i++)
                model[i] = '0;
            expect_a.delete();
            expect_b.delete();
            data_errors     = 0;
            orphan_errors   = 0;
            leftover_errors = 0;
            startup_errors  = 0;
            stall_cycles    = 0;
            first_cycle     = 1'b1;
            final_done      = 1'b0;
        end else begin
            if (first_cycle && (req_ready_a || req_ready_b || rsp_valid_a || rsp_valid_b)) begin
                startup_errors++;
                $display("Ready or response outputs were high in the first cycle after reset.");
            end
            if (!first_cycle && ((req_valid_a && !req_ready_a) || (req_valid_b && !req_ready_b)))
                stall_cycles++;
            first_cycle = 1'b0;

            // Responses first; a request accepted at this edge cannot answer yet.
            if (rsp_valid_a)
                check_response(1'b0, rsp_data_a);
            if (rsp_valid_b)
                check_response(1'b1, rsp_data_b);
            if (req_valid_a && req_ready_a)
                expect_a.push_back(apply_request(req_op_a, req_addr_a, req_wdata_a));
            if (req_valid_b && req_ready_b)
                expect_b.push_back(apply_request(req_op_b, req_addr_b, req_wdata_b));

            if (final_check && !final_done) begin
                leftover_errors = expect_a.size() + expect_b.size();
                if (leftover_errors != 0)
                    $display("%0d request(s) never received a response by the end of the run.",
                             leftover_errors);
                final_done = 1'b1;
            end
        end
        pending = expect_a.size() + expect_b.size();
    end

endmodule

/* bench/tb_banked_store.sv */
`timescale 1ns/1ps

module tb_banked_store import store_pkg::*; ();

    localparam int REQUESTS     = 600;  // Per requester.
    localparam int CLOCK_PERIOD = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int DRAIN_CYCLES = 50;
    localparam int TIMEOUT_NS   = 2 * REQUESTS * 8 * CLOCK_PERIOD;

    logic                 clock;
    logic                 reset;
    logic                 req_valid_a, req_valid_b;
    store_op_t            req_op_a, req_op_b;
    logic [ADDR_BITS-1:0] req_addr_a, req_addr_b;
    logic [SEG_BITS-1:0]  req_wdata_a, req_wdata_b;
    logic                 req_ready_a, req_ready_b;
    logic                 rsp_valid_a, rsp_valid_b;
    logic [SEG_BITS-1:0]  rsp_data_a, rsp_data_b;
    logic                 final_check;

    int data_errors, orphan_errors, leftover_errors, startup_errors;
    int stall_cycles, pending, other_errors, assert_errors, total_errors;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    banked_store UUT (.*);

    store_monitor monitor (.*);

    bind bank_arbiter store_chk arbiter_checks (
        .clock           (clock),
        .reset           (reset),
        .grant_a         (grant_a),
        .grant_b         (grant_b),
        .bank0_valid     (bank0.valid),
        .bank0_ready     (bank0.ready),
        .bank0_tag       (bank0.tag),
        .bank0_rsp_valid (bank0.rsp_valid),
        .bank1_valid     (bank1.valid),
        .bank1_ready     (bank1.ready),
        .bank1_tag       (bank1.tag),
        .bank1_rsp_valid (bank1.rsp_valid)
    );

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic set_request(input bit is_b, input logic valid, input store_op_t op,
                               input logic [ADDR_BITS-1:0] addr,
                               input logic [SEG_BITS-1:0] wdata);
        if (is_b) begin
            req_valid_b = valid;
            req_op_b    = op;
            req_addr_b  = addr;
            req_wdata_b = wdata;
        end else begin
            req_valid_a = valid;
            req_op_a    = op;
            req_addr_a  = addr;
            req_wdata_a = wdata;
        end
    endtask

    function automatic logic ready_seen(input bit is_b);
        return is_b ? req_ready_b : req_ready_a;
    endfunction

    // Port a keeps to rows 0 to 2 and port b to rows 8 to 10 of either bank.
    function automatic logic [ADDR_BITS-1:0] pick_address(input bit is_b);
        logic [BANK_BITS-1:0]     bank;
        logic [ROW_ADDR_BITS-1:0] row;
        logic [SEG_ADDR_BITS-1:0] seg;
        bank = BANK_BITS'($urandom_range(BANK_COUNT - 1, 0));
        row  = ROW_ADDR_BITS'($urandom_range(2, 0)) + (is_b ? ROW_ADDR_BITS'(8) : '0);
        seg  = SEG_ADDR_BITS'($urandom_range(SEGS_PER_ROW - 1, 0));
        return {bank, row, seg};
    endfunction

    task automatic run_requester(input bit is_b);
        int unsigned issued;
        int unsigned pick;
        store_op_t   op;
        issued = 0;
        while (issued < REQUESTS) begin
            pick = $urandom_range(7, 0);
            if (pick < 2) begin
                set_request(is_b, 1'b0, OP_READ, '0, '0);  // Idle for a cycle.
                @(posedge clock);
            end else begin
                op = (pick < 5) ? OP_READ : OP_WRITE;
                set_request(is_b, 1'b1, op, pick_address(is_b), SEG_BITS'($urandom));
                @(posedge clock);
                while (!ready_seen(is_b))
                    @(posedge clock);
                issued++;
            end
            #DRIVE_DELAY;
        end
        set_request(is_b, 1'b0, OP_READ, '0, '0);
    endtask

    // ----------------------------------------
    // Main sequence and report
    // ----------------------------------------
    initial begin
        int waited;
        void'($urandom(14407));
        clock        = 1'b0;
        reset        = 1'b1;
        final_check  = 1'b0;
        other_errors = 0;
        set_request(1'b0, 1'b0, OP_READ, '0, '0);
        set_request(1'b1, 1'b0, OP_READ, '0, '0);
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        fork
            run_requester(1'b0);
            run_requester(1'b1);
        join

        waited = 0;
        while (pending != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clock);
            #DRIVE_DELAY;
            waited++;
        end
        final_check = 1'b1;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;

        if (stall_cycles == 0) begin
            other_errors++;
            $display("req_ready never dropped while a request was waiting.");
        end
        assert_errors = UUT.arbiter.arbiter_checks.failures;
        total_errors  = data_errors + orphan_errors + leftover_errors + startup_errors +
                        assert_errors + other_errors;
        $write("Errors: data %0d, orphan %0d, outstanding %0d, ",
               data_errors, orphan_errors, leftover_errors);
        $display("startup %0d, assertion %0d, other %0d",
                 startup_errors, assert_errors, other_errors);
        if (total_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* rtl/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter import store_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    req_if.sink                 port_a,
    req_if.sink                 port_b,
    bank_if.host                bank0,
    bank_if.host                bank1,
    output logic                rsp_valid_a,
    output logic [SEG_BITS-1:0] rsp_data_a,
    output logic                rsp_valid_b,
    output logic [SEG_BITS-1:0] rsp_data_b
);
    logic                     in_flight_a;
    logic                     in_flight_b;
    logic                     last_b;       // Port b won the last single grant.
    logic [BANK_BITS-1:0]     target_a;
    logic [BANK_BITS-1:0]     target_b;
    logic [ROW_ADDR_BITS-1:0] row_a;
    logic [ROW_ADDR_BITS-1:0] row_b;
    logic [SEG_ADDR_BITS-1:0] seg_a;
    logic [SEG_ADDR_BITS-1:0] seg_b;
    logic                     want_a0, want_a1;
    logic                     want_b0, want_b1;
    logic                     pick_b0, pick_b1;
    logic                     grant_a, grant_b;
    logic                     done_a, done_b;

    assign target_a = port_a.addr[BANK_LSB +: BANK_BITS];
    assign target_b = port_b.addr[BANK_LSB +: BANK_BITS];
    assign row_a    = port_a.addr[ROW_LSB +: ROW_ADDR_BITS];
    assign row_b    = port_b.addr[ROW_LSB +: ROW_ADDR_BITS];
    assign seg_a    = port_a.addr[SEG_LSB +: SEG_ADDR_BITS];
    assign seg_b    = port_b.addr[SEG_LSB +: SEG_ADDR_BITS];

    // A port with a response pending is not offered again.
    assign want_a0 = port_a.valid && !in_flight_a && (target_a == BANK_BITS'(0));
    assign want_a1 = port_a.valid && !in_flight_a && (target_a == BANK_BITS'(1));
    assign want_b0 = port_b.valid && !in_flight_b && (target_b == BANK_BITS'(0));
    assign want_b1 = port_b.valid && !in_flight_b && (target_b == BANK_BITS'(1));

    // On a tie the port that did not win last time takes the bank.
    assign pick_b0 = want_b0 && (!want_a0 || !last_b);
    assign pick_b1 = want_b1 && (!want_a1 || !last_b);

    // ----------------------------------------
    // Request routing
    // ----------------------------------------
    // Only an idle bank sees valid, so the choice may change while a bank is busy.
    assign bank0.valid = (want_a0 || want_b0) && bank0.ready;
    assign bank0.tag   = pick_b0;
    assign bank0.op    = pick_b0 ? port_b.op : port_a.op;
    assign bank0.row   = pick_b0 ? row_b : row_a;
    assign bank0.seg   = pick_b0 ? seg_b : seg_a;
    assign bank0.wdata = pick_b0 ? port_b.wdata : port_a.wdata;

    assign bank1.valid = (want_a1 || want_b1) && bank1.ready;
    assign bank1.tag   = pick_b1;
    assign bank1.op    = pick_b1 ? port_b.op : port_a.op;
    assign bank1.row   = pick_b1 ? row_b : row_a;
    assign bank1.seg   = pick_b1 ? seg_b : seg_a;
    assign bank1.wdata = pick_b1 ? port_b.wdata : port_a.wdata;

    assign grant_a = (want_a0 && !pick_b0 && bank0.ready) ||
                     (want_a1 && !pick_b1 && bank1.ready);
    assign grant_b = (pick_b0 && bank0.ready) || (pick_b1 && bank1.ready);

    assign port_a.ready = grant_a;
    assign port_b.ready = grant_b;

    // ----------------------------------------
    // Response routing
    // ----------------------------------------
    assign done_a = (bank0.rsp_valid && !bank0.rsp_tag) || (bank1.rsp_valid && !bank1.rsp_tag);
    assign done_b = (bank0.rsp_valid && bank0.rsp_tag) || (bank1.rsp_valid && bank1.rsp_tag);

    assign rsp_valid_a = done_a;
    assign rsp_valid_b = done_b;
    assign rsp_data_a  = (bank0.rsp_valid && !bank0.rsp_tag) ? bank0.rsp_data : bank1.rsp_data;
    assign rsp_data_b  = (bank0.rsp_valid && bank0.rsp_tag) ? bank0.rsp_data : bank1.rsp_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            in_flight_a <= 1'b0;
            in_flight_b <= 1'b0;
            last_b      <= 1'b0;
        end else begin
            if (grant_a)
                in_flight_a <= 1'b1;
            else if (done_a)
                in_flight_a <= 1'b0;
            if (grant_b)
                in_flight_b <= 1'b1;
            else if (done_b)
                in_flight_b <= 1'b0;
            if (grant_a != grant_b)
                last_b <= grant_b;  // Two grants at once leave the order as it was.
        end
    end

endmodule

/* rtl/bank_controller.sv */
`timescale 1ns/1ps

module bank_controller import store_pkg::*; (
    input  logic clock,
    input  logic reset,
    bank_if.bank bus
);
    bank_state_t              state;
    logic [ROW_COUNT-1:0]     dirty;
    logic                     buf_valid;
    logic [ROW_ADDR_BITS-1:0] buf_row;
    logic [ROW_BITS-1:0]      row_buf;

    store_op_t                req_op;
    logic [ROW_ADDR_BITS-1:0] req_row;
    logic [SEG_ADDR_BITS-1:0] req_seg;
    logic [SEG_BITS-1:0]      req_wdata;
    logic                     req_tag;
    logic                     rsp_valid;
    logic [SEG_BITS-1:0]      rsp_data;

    logic                     accept;
    logic                     row_dirty;
    logic                     row_hit;
    logic                     fetch_start;
    logic                     ram_enable;
    logic                     ram_write;
    logic [ROW_ADDR_BITS-1:0] ram_addr;
    logic [ROW_BITS-1:0]      ram_rdata;

    function automatic logic [ROW_BITS-1:0] merge_seg(
        input logic [ROW_BITS-1:0]      row,
        input logic [SEG_ADDR_BITS-1:0] seg,
        input logic [SEG_BITS-1:0]      data
    );
        logic [ROW_BITS-1:0] merged;
        merged = row;
        merged[seg * SEG_BITS +: SEG_BITS] = data;
        return merged;
    endfunction

    function automatic logic [SEG_BITS-1:0] seg_of(
        input logic [ROW_BITS-1:0]      row,
        input logic [SEG_ADDR_BITS-1:0] seg
    );
        return row[seg * SEG_BITS +: SEG_BITS];
    endfunction

    row_ram ram (
        .clock      (clock),
        .enable     (ram_enable),
        .write_en   (ram_write),
        .addr       (ram_addr),
        .write_data (row_buf),
        .read_data  (ram_rdata)
    );

    assign bus.ready     = (state == BANK_IDLE);
    assign bus.rsp_valid = rsp_valid;
    assign bus.rsp_data  = rsp_data;
    assign bus.rsp_tag   = req_tag;

    assign accept    = bus.valid && bus.ready;
    assign row_dirty = dirty[bus.row];
    assign row_hit   = buf_valid && (buf_row == bus.row);

    // Only a written row that is not in the buffer needs the RAM.
    assign fetch_start = accept && row_dirty && !row_hit;
    assign ram_write   = (state == BANK_WRITEBACK);
    assign ram_enable  = fetch_start || ram_write;
    assign ram_addr    = (state == BANK_IDLE) ? bus.row : req_row;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= BANK_IDLE;
            dirty     <= '0;
            buf_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                BANK_IDLE: begin
                    if (accept) begin
                        if (fetch_start) begin
                            state <= BANK_FETCH;
                        end else if (bus.op == OP_WRITE) begin
                            dirty[bus.row] <= 1'b1;
                            buf_valid      <= 1'b1;
                            state          <= BANK_WRITEBACK;
                        end else begin
                            rsp_valid <= 1'b1;  // Hit or clean row.
                        end
                    end
                end
                BANK_FETCH: begin
                    buf_valid <= 1'b1;
                    if (req_op == OP_WRITE) begin
                        state <= BANK_WRITEBACK;
                    end else begin
                        rsp_valid <= 1'b1;
                        state     <= BANK_IDLE;
                    end
                end
                BANK_WRITEBACK: begin
                    rsp_valid <= 1'b1;
                    state     <= BANK_IDLE;
                end
                default: state <= BANK_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Row buffer and response data
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (accept) begin
            req_op    <= bus.op;
            req_row   <= bus.row;
            req_seg   <= bus.seg;
            req_wdata <= bus.wdata;
            req_tag   <= bus.tag;
            rsp_data  <= (row_dirty && row_hit) ? seg_of(row_buf, bus.seg) : '0;
            if (bus.op == OP_WRITE && !row_dirty) begin
                // First write to the row, so the other segments start at zero.
                row_buf <= merge_seg('0, bus.seg, bus.wdata);
                buf_row <= bus.row;
            end else if (bus.op == OP_WRITE && row_hit) begin
                row_buf <= merge_seg(row_buf, bus.seg, bus.wdata);
            end
        end
        if (state == BANK_FETCH) begin
            buf_row  <= req_row;
            row_buf  <= (req_op == OP_WRITE) ? merge_seg(ram_rdata, req_seg, req_wdata)
                                             : ram_rdata;
            rsp_data <= seg_of(ram_rdata, req_seg);
        end
        if (state == BANK_WRITEBACK)
            rsp_data <= '0;  // A write answers with zero.
    end

endmodule

/* rtl/banked_store.sv */
`timescale 1ns/1ps

module banked_store import store_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 req_valid_a,
    input  store_op_t            req_op_a,
    input  logic [ADDR_BITS-1:0] req_addr_a,
    input  logic [SEG_BITS-1:0]  req_wdata_a,
    output logic                 req_ready_a,
    output logic                 rsp_valid_a,
    output logic [SEG_BITS-1:0]  rsp_data_a,

    input  logic                 req_valid_b,
    input  store_op_t            req_op_b,
    input  logic [ADDR_BITS-1:0] req_addr_b,
    input  logic [SEG_BITS-1:0]  req_wdata_b,
    output logic                 req_ready_b,
    output logic                 rsp_valid_b,
    output logic [SEG_BITS-1:0]  rsp_data_b
);
    req_if  req_a ();
    req_if  req_b ();
    bank_if bus0 ();
    bank_if bus1 ();

    request_queue queue_a (
        .clock    (clock),
        .reset    (reset),
        .in_valid (req_valid_a),
        .in_ready (req_ready_a),
        .in_op    (req_op_a),
        .in_addr  (req_addr_a),
        .in_wdata (req_wdata_a),
        .out      (req_a.source)
    );

    request_queue queue_b (
        .clock    (clock),
        .reset    (reset),
        .in_valid (req_valid_b),
        .in_ready (req_ready_b),
        .in_op    (req_op_b),
        .in_addr  (req_addr_b),
        .in_wdata (req_wdata_b),
        .out      (req_b.source)
    );

    bank_arbiter arbiter (
        .clock       (clock),
        .reset       (reset),
        .port_a      (req_a.sink),
        .port_b      (req_b.sink),
        .bank0       (bus0.host),
        .bank1       (bus1.host),
        .rsp_valid_a (rsp_valid_a),
        .rsp_data_a  (rsp_data_a),
        .rsp_valid_b (rsp_valid_b),
        .rsp_data_b  (rsp_data_b)
    );

    bank_controller bank0 (.clock(clock), .reset(reset), .bus(bus0.bank));
    bank_controller bank1 (.clock(clock), .reset(reset), .bus(bus1.bank));

endmodule

/* rtl/request_queue.sv */
`timescale 1ns/1ps

module request_queue import store_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  store_op_t            in_op,
    input  logic [ADDR_BITS-1:0] in_addr,
    input  logic [SEG_BITS-1:0]  in_wdata,
    req_if.source                out
);
    store_op_t            entry_op    [QUEUE_DEPTH];
    logic [ADDR_BITS-1:0] entry_addr  [QUEUE_DEPTH];
    logic [SEG_BITS-1:0]  entry_wdata [QUEUE_DEPTH];

    logic [QUEUE_PTR_BITS-1:0]   head;
    logic [QUEUE_PTR_BITS-1:0]   tail;
    logic [QUEUE_COUNT_BITS-1:0] count;
    logic                        live;
    logic                        push;
    logic                        pop;

    function automatic logic [QUEUE_PTR_BITS-1:0] next_ptr(
        input logic [QUEUE_PTR_BITS-1:0] ptr
    );
        if (ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1))
            return '0;
        return ptr + QUEUE_PTR_BITS'(1);
    endfunction

    // The live flag holds ready low for the first cycle out of reset.
    assign in_ready = live && (count != QUEUE_COUNT_BITS'(QUEUE_DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = out.valid && out.ready;

    assign out.valid = (count != '0);
    assign out.op    = entry_op[head];
    assign out.addr  = entry_addr[head];
    assign out.wdata = entry_wdata[head];

    always_ff @(posedge clock) begin
        if (push) begin
            entry_op[tail]    <= in_op;
            entry_addr[tail]  <= in_addr;
            entry_wdata[tail] <= in_wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            live  <= 1'b0;
        end else begin
            live <= 1'b1;
            if (push)
                tail <= next_ptr(tail);
            if (pop)
                head <= next_ptr(head);
            if (push && !pop)
                count <= count + QUEUE_COUNT_BITS'(1);
            else if (pop && !push)
                count <= count - QUEUE_COUNT_BITS'(1);
        end
    end

endmodule

/* rtl/row_ram.sv */
`timescale 1ns/1ps

module row_ram import store_pkg::*; (
    input  logic                     clock,
    input  logic                     enable,
    input  logic                     write_en,
    input  logic [ROW_ADDR_BITS-1:0] addr,
    input  logic [ROW_BITS-1:0]      write_data,
    output logic [ROW_BITS-1:0]      read_data
);
    logic [ROW_BITS-1:0] mem [ROW_COUNT];

    // A write leaves read_data holding the last read.
    always_ff @(posedge clock) begin
        if (enable) begin
            if (write_en)
                mem[addr] <= write_data;
            else
                read_data <= mem[addr];
        end
    end

endmodule

/* rtl/store_ifs.sv */
`timescale 1ns/1ps

// One request from a queue head towards the arbiter.
interface req_if import store_pkg::*; ();
    logic                 valid;
    logic                 ready;
    store_op_t            op;
    logic [ADDR_BITS-1:0] addr;
    logic [SEG_BITS-1:0]  wdata;

    modport source (output valid, op, addr, wdata, input ready);
    modport sink (input valid, op, addr, wdata, output ready);
endinterface

// Arbiter to one bank controller. A tag of 1 names port b.
interface bank_if import store_pkg::*; ();
    logic                     valid;
    logic                     ready;
    store_op_t                op;
    logic [ROW_ADDR_BITS-1:0] row;
    logic [SEG_ADDR_BITS-1:0] seg;
    logic [SEG_BITS-1:0]      wdata;
    logic                     tag;
    logic                     rsp_valid;
    logic [SEG_BITS-1:0]      rsp_data;
    logic                     rsp_tag;

    modport host (output valid, op, row, seg, wdata, tag,
                  input ready, rsp_valid, rsp_data, rsp_tag);
    modport bank (input valid, op, row, seg, wdata, tag,
                  output ready, rsp_valid, rsp_data, rsp_tag);
endinterface

/* rtl/store_pkg.sv */
package store_pkg;

    // ----------------------------------------
    // Storage geometry
    // ----------------------------------------
    localparam int SEG_BITS      = 16;
    localparam int ROW_BITS      = 64;
    localparam int SEGS_PER_ROW  = ROW_BITS / SEG_BITS;
    localparam int ROW_COUNT     = 16;
    localparam int ROW_ADDR_BITS = $clog2(ROW_COUNT);
    localparam int BANK_COUNT    = 2;
    localparam int BANK_BITS     = $clog2(BANK_COUNT);
    localparam int SEG_ADDR_BITS = $clog2(SEGS_PER_ROW);

    // The address reads bank, row, segment from the top down.
    localparam int ADDR_BITS = BANK_BITS + ROW_ADDR_BITS + SEG_ADDR_BITS;
    localparam int SEG_LSB   = 0;
    localparam int ROW_LSB   = SEG_LSB + SEG_ADDR_BITS;
    localparam int BANK_LSB  = ROW_LSB + ROW_ADDR_BITS;

    // ----------------------------------------
    // Request queues
    // ----------------------------------------
    localparam int QUEUE_DEPTH      = 2;
    localparam int QUEUE_PTR_BITS   = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } store_op_t;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_FETCH,
        BANK_WRITEBACK
    } bank_state_t;

endpackage

/* sim.f */
rtl/store_pkg.sv
rtl/store_ifs.sv
rtl/row_ram.sv
rtl/request_queue.sv
rtl/bank_arbiter.sv
rtl/bank_controller.sv
rtl/banked_store.sv
bench/store_chk.sv
bench/store_monitor.sv
bench/tb_banked_store.sv
